// File: logic/l15_bridge_pkg.sv
/*
  shared types for the core bus to L1.5 bridge
  request data and return data are big-endian 64-bit words
  only 1, 2 and 4 byte accesses exist, no 8-byte or block traffic
  rq_none aliases load_rq and only marks an idle request bus
*/
package l15_bridge_pkg;

    // address widths on each side of the bridge
    localparam int PICO_ADDR_W = 32;
    localparam int L15_ADDR_W  = 40;

    // L1.5 request types, only the two the core can produce
    typedef enum logic [4:0] {
        load_rq  = 5'd0,
        store_rq = 5'd1
    } l15_rqtype_e;

    // idle request code, same encoding as a load
    localparam l15_rqtype_e rq_none = load_rq;

    // access size codes on the request packet
    typedef enum logic [2:0] {
        sz_1b = 3'd0,
        sz_2b = 3'd1,
        sz_4b = 3'd2
    } l15_size_e;

    // L1.5 return types seen by this bridge
    typedef enum logic [3:0] {
        load_ret = 4'd0,
        st_ack   = 4'd4
    } l15_rettype_e;

    // one core access as seen on the native memory bus
    typedef struct packed {
        logic [PICO_ADDR_W-1:0] addr;
        logic [3:0]             wstrb;
        logic [31:0]            wdata;
        logic                   valid;
    } pico_req_t;

    // request packet towards the L1.5
    typedef struct packed {
        logic                  val;
        l15_rqtype_e           rqtype;
        l15_size_e             size;
        logic [L15_ADDR_W-1:0] address;
        logic [63:0]           data;
        // non-cacheable, taken from the top address bit
        logic                  nc;
    } l15_req_t;

    // return packet from the L1.5
    typedef struct packed {
        logic         val;
        l15_rettype_e rettype;
        logic [63:0]  data0;
    } l15_ret_t;

    // reverse the byte order of a 32-bit word
    // used both ways, little to big endian and back
    function automatic logic [31:0] bswap32(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

// File: logic/pico_decoder.sv
/*
  turns each new core access into one L1.5 load or store request
  the core must hold addr, wstrb and wdata stable until mem_ready
  legal strobes are 1111, 1100, 0011 and single bytes only
  the request is held valid until the L1.5 acks it
*/
`timescale 1ns/10ps

module pico_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  l15_bridge_pkg::pico_req_t mem_in,
    input  logic                     l15_req_ack,
    output l15_bridge_pkg::l15_req_t  l15_req
);
    import l15_bridge_pkg::*;

    typedef enum logic {
        ack_idle = 1'b0,
        ack_wait = 1'b1
    } ack_state_e;

    // index of the lowest strobed byte lane
    function automatic logic [1:0] lowest_byte(input logic [3:0] strb);
        logic [1:0] idx;
        idx = 2'd0;
        // scan from the top so the lowest set lane wins
        for (int i = 3; i >= 0; i--) begin
            if (strb[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    logic        valid_q1;
    logic        valid_q2;
    logic        new_request;
    ack_state_e  ack_state;
    ack_state_e  ack_next;
    logic        req_val;
    logic        is_store;
    logic        strobe_legal;
    l15_size_e   store_size;
    logic [1:0]  byte_off;

    // two flops on valid to catch its rising edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= mem_in.valid;
            valid_q2 <= valid_q1;
        end
    end

    // one cycle wide, one cycle after valid first rises
    assign new_request = valid_q1 & ~valid_q2;

    // ack tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_state <= ack_idle;
        end else begin
            ack_state <= ack_next;
        end
    end

    always_comb begin
        // an ack closes the request even if a new one shows up
        if (l15_req_ack) begin
            ack_next = ack_idle;
        end else if (new_request) begin
            ack_next = ack_wait;
        end else begin
            ack_next = ack_state;
        end
    end

    // waiting keeps val up with the core, idle only opens on a new access
    assign req_val = (ack_state == ack_wait) ? mem_in.valid : new_request;

    // any strobe bit set means a store
    assign is_store = |mem_in.wstrb;

    // size from the strobe pattern
    always_comb begin
        strobe_legal = 1'b1;
        case (mem_in.wstrb)
            4'b0000, 4'b1111: begin
                store_size = sz_4b;
            end
            4'b1100, 4'b0011: begin
                store_size = sz_2b;
            end
            4'b1000, 4'b0100, 4'b0010, 4'b0001: begin
                store_size = sz_1b;
            end
            default: begin
                // misaligned or three-byte pattern
                store_size   = sz_1b;
                strobe_legal = 1'b0;
            end
        endcase
    end

    // stores point at their first written byte, loads stay as given
    assign byte_off = is_store ? lowest_byte(mem_in.wstrb) : mem_in.addr[1:0];

    // request packet assembly
    always_comb begin
        l15_req     = '0;
        l15_req.val = req_val;
        l15_req.nc  = mem_in.addr[PICO_ADDR_W-1];
        // sign-extend the core address up to the L1.5 width
        l15_req.address = {{(L15_ADDR_W-PICO_ADDR_W){mem_in.addr[PICO_ADDR_W-1]}},
                           mem_in.addr[PICO_ADDR_W-1:2], byte_off};
        if (mem_in.valid) begin
            if (is_store) begin
                l15_req.rqtype = store_rq;
                l15_req.size   = store_size;
                // big-endian word, same copy in both halves
                l15_req.data   = {2{bswap32(mem_in.wdata)}};
            end else begin
                l15_req.rqtype = load_rq;
                l15_req.size   = sz_4b;
            end
        end else begin
            l15_req.rqtype = rq_none;
        end
    end

    // the core only issues the strobe patterns the L1.5 sizes can express
    a_strobe_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_in.valid |-> strobe_legal
    ) else $error("illegal write strobe pattern %b", mem_in.wstrb);

    // an unacked request must not see its address move under it
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (l15_req.val && !l15_req_ack) |=> $stable(mem_in.addr)
    ) else $error("core address changed while request pending");

endmodule

// File: logic/pico_encoder.sv
/*
  turns an L1.5 return into the core's ready pulse and read data
  every return is acked in the same cycle it arrives
  addr_bit2 must still hold the address of the pending access
  mem_rdata is only meaningful in the mem_ready cycle
*/
`timescale 1ns/10ps

module pico_encoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     addr_bit2,
    input  l15_bridge_pkg::l15_ret_t  l15_ret,
    output logic                     l15_ret_ack,
    output logic                     mem_ready,
    output logic [31:0]              mem_rdata
);
    import l15_bridge_pkg::*;

    logic [31:0] ret_half;
    logic [31:0] ret_word;

    // the bridge never stalls a return
    assign l15_ret_ack = l15_ret.val;

    // pick the 32-bit half of the 64-bit return
    // big-endian, so the lower address sits in the upper half
    assign ret_half = addr_bit2 ? l15_ret.data0[31:0] : l15_ret.data0[63:32];

    // word handed back to the core
    always_comb begin
        case (l15_ret.rettype)
            load_ret: begin
                // back to little-endian lanes
                ret_word = bswap32(ret_half);
            end
            st_ack: begin
                ret_word = 32'h0;
            end
            default: begin
                ret_word = 32'h0;
            end
        endcase
    end

    // ready pulse one cycle after the return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= l15_ret.val;
        end
    end

    // read data captured with the return, held until the next one
    always_ff @(posedge clk) begin
        if (l15_ret.val) begin
            mem_rdata <= ret_word;
        end
    end

    // one access in flight, so the L1.5 never returns back to back
    a_ret_spaced: assert property (
        @(posedge clk) disable iff (!rst_n)
        l15_ret.val |=> !l15_ret.val
    ) else $error("L1.5 return in two consecutive cycles");

endmodule

// File: logic/pico_l15_bridge.sv
/*
  core memory bus to L1.5 bridge, one access in flight at a time
  the core holds its request until mem_ready, then drops valid
  back-pressure on requests is only the missing l15_req_ack
*/
`timescale 1ns/10ps

module pico_l15_bridge (
    input  logic                     clk,
    input  logic                     rst_n,
    // core side
    input  l15_bridge_pkg::pico_req_t mem_in,
    output logic                     mem_ready,
    output logic [31:0]              mem_rdata,
    // L1.5 request side
    output l15_bridge_pkg::l15_req_t  l15_req,
    input  logic                     l15_req_ack,
    // L1.5 return side
    input  l15_bridge_pkg::l15_ret_t  l15_ret,
    output logic                     l15_ret_ack
);

    // word select for the return, held by the core during the access
    logic addr_bit2;

    assign addr_bit2 = mem_in.addr[2];

    // core access to L1.5 request
    pico_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_in      (mem_in),
        .l15_req_ack (l15_req_ack),
        .l15_req     (l15_req)
    );

    // L1.5 return to core ready and read data
    pico_encoder u_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_bit2   (addr_bit2),
        .l15_ret     (l15_ret),
        .l15_ret_ack (l15_ret_ack),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

endmodule

// File: tb/l15_mem_model.sv
/*
  behavioral L1.5 for the bridge testbench, one request at a time
  64 bytes of backing store, big-endian inside each doubleword
  only address bits 5:0 pick a byte, higher bits alias
  acks 0 to 3 cycles after a request is seen, returns 1 to 4 after the ack
*/
`timescale 1ns/10ps

module l15_mem_model (
    input  logic                     clk,
    input  l15_bridge_pkg::l15_req_t  l15_req,
    output logic                     l15_req_ack,
    output l15_bridge_pkg::l15_ret_t  l15_ret
);
    import l15_bridge_pkg::*;

    logic [7:0]  mem [0:63];
    l15_req_t    req_q;
    int unsigned ack_delay;
    int unsigned ret_delay;

    // byte 0 of the doubleword lands in bits 63:56
    function automatic logic [63:0] read_dword(input logic [2:0] dw);
        logic [63:0] d;
        d = '0;
        for (int k = 0; k < 8; k++) begin
            d = {d[55:0], mem[{dw, 3'(k)}]};
        end
        return d;
    endfunction

    // writes only the bytes covered by size and the low address bits
    task automatic write_store(input l15_req_t r);
        int         nbytes;
        int         first;
        logic [5:0] idx;
        case (r.size)
            sz_1b: nbytes = 1;
            sz_2b: nbytes = 2;
            default: nbytes = 4;
        endcase
        // accesses are naturally aligned inside the doubleword
        first = int'(r.address[2:0]) & ~(nbytes - 1);
        for (int k = first; k < first + nbytes; k++) begin
            idx = {r.address[5:3], 3'(k)};
            mem[idx] = 8'(r.data >> (8 * (7 - k)));
        end
    endtask

    initial begin
        // initial contents match the testbench reference memory
        for (int a = 0; a < 64; a++) begin
            mem[6'(a)] = 8'(a * 29 + 7);
        end
        l15_req_ack = 1'b0;
        l15_ret     = '0;
        forever begin
            // look at the request bus mid-cycle, well away from both edges
            @(negedge clk);
            if (l15_req.val === 1'b1) begin
                req_q     = l15_req;
                ack_delay = $urandom_range(3, 0);
                ret_delay = $urandom_range(4, 1);
                repeat (ack_delay + 1) @(posedge clk);
                #2;
                l15_req_ack = 1'b1;
                // ack is a single cycle, the return follows ret_delay cycles on
                repeat (ret_delay) begin
                    @(posedge clk);
                    #2;
                    l15_req_ack = 1'b0;
                end
                l15_ret.val = 1'b1;
                if (req_q.rqtype == store_rq) begin
                    write_store(req_q);
                    l15_ret.rettype = st_ack;
                    l15_ret.data0   = '0;
                end else begin
                    l15_ret.rettype = load_ret;
                    l15_ret.data0   = read_dword(req_q.address[5:3]);
                end
                @(posedge clk);
                #2;
                l15_ret = '0;
            end
        end
    end

endmodule

// File: tb/tb_pico_l15_bridge.sv
/*
  testbench for the core bus to L1.5 bridge, acting as the core
  fixed accesses first, then random loads and stores over 16 words
  core addresses are word aligned, bit 31 toggles the nc region
  the reference memory is little-endian and aliases like the L1.5 model
*/
`timescale 1ns/10ps

module tb_pico_l15_bridge;
    import l15_bridge_pkg::*;

    localparam int fixed_count    = 12;
    localparam int random_count   = 36;
    localparam int timeout_cycles = (fixed_count + random_count) * 12 + 50;

    logic        clk;
    logic        rst_n;
    pico_req_t   mem_in;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    l15_req_t    l15_req;
    logic        l15_req_ack;
    l15_ret_t    l15_ret;
    logic        l15_ret_ack;

    logic [7:0]  ref_mem [0:63];
    logic [3:0]  legal_strb [0:6];
    logic [31:0] exp_rdata;
    int          access_count;
    int          rise_count;
    logic        val_q;
    int          error_count;

    pico_l15_bridge pico_l15_bridge_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_in      (mem_in),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .l15_req     (l15_req),
        .l15_req_ack (l15_req_ack),
        .l15_ret     (l15_ret),
        .l15_ret_ack (l15_ret_ack)
    );

    l15_mem_model mem_model_inst (
        .clk         (clk),
        .l15_req     (l15_req),
        .l15_req_ack (l15_req_ack),
        .l15_ret     (l15_ret)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // rising edges of request val
    always @(posedge clk) begin
        if (!rst_n) begin
            val_q      <= 1'b0;
            rise_count <= 0;
        end else begin
            val_q <= l15_req.val;
            if (l15_req.val && !val_q) begin
                rise_count <= rise_count + 1;
            end
        end
    end

    // 1, 2 or 4 strobed bytes, a load counts as a full word
    function automatic l15_size_e expected_size(input logic [3:0] strb);
        l15_size_e sz;
        case ($countones(strb))
            1: sz = sz_1b;
            2: sz = sz_2b;
            default: sz = sz_4b;
        endcase
        return sz;
    endfunction

    // sign-extended, stores point at their lowest strobed byte
    function automatic logic [39:0] expected_address(input logic [31:0] a,
                                                     input logic [3:0]  strb);
        logic [39:0] ea;
        logic        found;
        ea    = {{8{a[31]}}, a};
        found = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (strb[i] && !found) begin
                ea[1:0] = 2'(i);
                found   = 1'b1;
            end
        end
        return ea;
    endfunction

    // both halves equal, core byte 0 in the top lane of each half
    function automatic bit store_data_ok(input logic [63:0] data, input logic [31:0] wdata);
        bit ok;
        ok = (data[63:32] == data[31:0]);
        for (int k = 0; k < 4; k++) begin
            if (8'(data >> (8 * (3 - k))) != 8'(wdata >> (8 * k))) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> mem_rdata == exp_rdata
    ) else begin
        error_count++;
        $display("ERROR mem_rdata got %h expected %h", mem_rdata, exp_rdata);
    end

    a_rqtype: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req.val |-> l15_req.rqtype == ((mem_in.wstrb == 4'b0) ? load_rq : store_rq)
    ) else begin
        error_count++;
        $display("ERROR l15_req.rqtype got %h for wstrb %h", l15_req.rqtype, mem_in.wstrb);
    end

    a_size: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req.val |-> l15_req.size == expected_size(mem_in.wstrb)
    ) else begin
        error_count++;
        $display("ERROR l15_req.size got %h expected %h", l15_req.size,
                 expected_size(mem_in.wstrb));
    end

    a_address: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req.val |-> l15_req.address == expected_address(mem_in.addr, mem_in.wstrb)
    ) else begin
        error_count++;
        $display("ERROR l15_req.address got %h expected %h", l15_req.address,
                 expected_address(mem_in.addr, mem_in.wstrb));
    end

    a_nc: assert property (@(posedge clk) disable iff (!rst_n)
        l15_req.val |-> l15_req.nc == mem_in.addr[31]
    ) else begin
        error_count++;
        $display("ERROR l15_req.nc got %h expected %h", l15_req.nc, mem_in.addr[31]);
    end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_req.val && mem_in.wstrb != 4'b0) |-> store_data_ok(l15_req.data, mem_in.wdata)
    ) else begin
        error_count++;
        $display("ERROR l15_req.data got %h for wdata %h", l15_req.data, mem_in.wdata);
    end

    // request held until acked, gone the cycle after
    a_val_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_req.val && !l15_req_ack) |=> l15_req.val
    ) else begin
        error_count++;
        $display("request val dropped before the L1.5 acked it");
    end

    a_val_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (l15_req.val && l15_req_ack) |=> !l15_req.val
    ) else begin
        error_count++;
        $display("request val still high in the cycle after its ack");
    end

    a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> rise_count == access_count
    ) else begin
        error_count++;
        $display("ERROR request count got %h expected %h", rise_count, access_count);
    end

    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready
    ) else begin
        error_count++;
        $display("mem_ready stayed high for more than one cycle");
    end

    a_ready_after_ret: assert property (@(posedge clk) disable iff (!rst_n)
        l15_ret.val |=> mem_ready
    ) else begin
        error_count++;
        $display("mem_ready missing in the cycle after an L1.5 return");
    end

    a_ready_has_ret: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> $past(l15_ret.val)
    ) else begin
        error_count++;
        $display("mem_ready without an L1.5 return in the cycle before");
    end

    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> mem_in.valid
    ) else begin
        error_count++;
        $display("mem_ready while the core had no access open");
    end

    // return ack is high exactly in the return cycles
    a_ret_ack: assert property (@(posedge clk) disable iff (!rst_n)
        l15_ret_ack == l15_ret.val
    ) else begin
        error_count++;
        $display("ERROR l15_ret_ack got %h expected %h", l15_ret_ack, l15_ret.val);
    end

    // checked through reset and in the first cycle after it
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!l15_req.val && !l15_ret_ack && !mem_ready)
    ) else begin
        error_count++;
        $display("bridge outputs active during or right after reset");
    end

    // one core access, open until mem_ready, reference updated at the end
    task automatic do_access(input logic [31:0] addr, input logic [3:0] strb,
                             input logic [31:0] wdata);
        logic [3:0] w;
        w = addr[5:2];
        @(posedge clk);
        #2;
        if (strb == 4'b0) begin
            exp_rdata = {ref_mem[{w, 2'd3}], ref_mem[{w, 2'd2}],
                         ref_mem[{w, 2'd1}], ref_mem[{w, 2'd0}]};
        end else begin
            exp_rdata = 32'h0;
        end
        mem_in.addr  = addr;
        mem_in.wstrb = strb;
        mem_in.wdata = wdata;
        mem_in.valid = 1'b1;
        access_count++;
        do begin
            @(negedge clk);
        end while (mem_ready !== 1'b1);
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                ref_mem[{w, 2'(k)}] = 8'(wdata >> (8 * k));
            end
        end
        // valid drops the cycle after ready
        @(posedge clk);
        #2;
        mem_in.valid = 1'b0;
    endtask

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the bridge stopped answering", cycle_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int          pick;
        logic [31:0] addr;
        void'($urandom(46));
        rst_n        = 1'b0;
        mem_in       = '0;
        exp_rdata    = '0;
        access_count = 0;
        error_count  = 0;
        legal_strb   = '{4'b1111, 4'b1100, 4'b0011, 4'b1000, 4'b0100, 4'b0010, 4'b0001};
        for (int a = 0; a < 64; a++) begin
            ref_mem[6'(a)] = 8'(a * 29 + 7);
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // load after store, narrow stores, both address halves, nc region
        do_access(32'h0000_0008, 4'b1111, 32'hdead_beef);
        do_access(32'h0000_0008, 4'b0000, 32'h0);
        do_access(32'h0000_0008, 4'b0010, 32'h0000_a500);
        do_access(32'h8000_000c, 4'b1100, 32'h1234_0000);
        do_access(32'h0000_0008, 4'b0000, 32'h0);
        do_access(32'h8000_000c, 4'b0000, 32'h0);
        do_access(32'h0000_0004, 4'b1000, 32'h7700_0000);
        do_access(32'h0000_0004, 4'b0001, 32'h0000_0011);
        do_access(32'h0000_0004, 4'b0100, 32'h0066_0000);
        do_access(32'h0000_0004, 4'b0000, 32'h0);
        do_access(32'h8000_0030, 4'b0011, 32'h0000_beef);
        do_access(32'h0000_0030, 4'b0000, 32'h0);

        // random mix, roughly one load in three
        for (int n = 0; n < random_count; n++) begin
            pick = int'($urandom_range(9, 0));
            addr = {1'($urandom_range(1, 0)), 25'd0, 4'($urandom_range(15, 0)), 2'b00};
            if (pick < 3) begin
                do_access(addr, 4'b0000, 32'h0);
            end else begin
                do_access(addr, legal_strb[pick - 3], $urandom);
            end
        end

        repeat (3) @(posedge clk);
        a_request_total: assert (rise_count == access_count) else begin
            error_count++;
            $display("ERROR request count got %h expected %h", rise_count, access_count);
        end

        $display("accesses: %0d, errors: %0d", access_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
logic/l15_bridge_pkg.sv
logic/pico_decoder.sv
logic/pico_encoder.sv
logic/pico_l15_bridge.sv
tb/l15_mem_model.sv
tb/tb_pico_l15_bridge.sv

// File: Makefile
# Verilator build and run for the core bus to L1.5 bridge

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_pico_l15_bridge
FILELIST = build.f

BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# fails on a non-zero exit or on the fail message in the log
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
